// ==== bench/tilemap_video_tests.txt ====
# W addr data : CPU write, hex address and hex 12-bit word
# F : wait for next frame start    C x y rgb : pixel check, decimal x y, hex rgb
# Palette, BG pens 1-4, FG pens 4 and 5 at 16 + pen
W 41 f00
W 42 0f0
W 43 00f
W 44 ff0
W 54 f0f
W 55 0ff
# BG tile row 0 and two tiles of row 1
W 00 001
W 01 002
W 02 003
W 03 004
W 04 001
W 05 002
W 06 003
W 07 004
W 08 003
W 09 001
# FG row 0, opaque pen 5 at col 2, transparent pen 6 at col 3
W 20 000
W 21 000
W 22 015
W 23 006
W 24 000
W 25 000
W 26 000
W 27 000
W 28 000
W 29 014
F
C 5 0 f00
C 0 3 f00
C 9 3 0f0
C 17 3 0ff
C 25 3 ff0
C 63 3 ff0
C 40 7 0f0
C 2 10 00f
C 12 10 f0f
# Scroll, BG by 12 and FG by 60 so it wraps
F
W 60 00c
W 61 03c
F
C 0 3 0f0
C 4 3 00f
C 12 3 ff0
C 20 3 0ff
C 27 3 0ff
C 28 3 0f0
C 52 3 f00
C 63 3 0f0
# Tile and palette writes during active video
F
W 05 006
W 46 a5c
W 41 123
W 22 005
F
C 0 3 0f0
C 4 3 00f
C 12 3 ff0
C 20 3 123
C 28 3 a5c
C 52 3 123
C 63 3 0f0

// ==== filelist.f ====
+incdir+hw
hw/tilemap_pkg.sv
hw/video_timing.sv
hw/layer_fetch.sv
hw/vram_bus.sv
hw/layer_mixer.sv
hw/tilemap_video.sv
bench/tilemap_video_chk.sv
bench/tilemap_video_tb.sv

// ==== Bender.yml ====
package:
  name: tilemap_video

sources:
  - include_dirs:
      - hw
    files:
      - hw/tilemap_pkg.sv
      - hw/video_timing.sv
      - hw/layer_fetch.sv
      - hw/vram_bus.sv
      - hw/layer_mixer.sv
      - hw/tilemap_video.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - bench/tilemap_video_chk.sv
      - bench/tilemap_video_tb.sv

// ==== bench/tilemap_video_tb.sv ====
`timescale 1ns/1ns
`include "tilemap_config.svh"

module tilemap_video_tb;
	import tilemap_pkg::*;

	localparam int clk_half    = 20;
	localparam int ack_limit   = 64;
	localparam int frame_limit = 4 * `TM_H_TOTAL * `TM_V_TOTAL;
	localparam int hsync_len   = `TM_HSYNC_END - `TM_HSYNC_START + 1;
	// Vsync measured in vid_ce samples over whole lines
	localparam int vsync_len   = (`TM_VSYNC_END - `TM_VSYNC_START + 1) * `TM_H_TOTAL;

	logic       clk;
	logic       arst_n;
	cpu_wr_t    cpu_wr;
	logic       cpu_req;
	logic       cpu_ack;
	video_out_t video;
	logic       vid_ce;

	int   err_cnt;
	int   check_cnt;
	int   pix_checks;
	logic timed_out;

	// Raster tracker updated on the falling edge
	int          x_cnt;
	int          y_cnt;
	int          hs_cnt;
	int          vs_cnt;
	int          hs_pulses;
	int          vs_pulses;
	int          frame_cnt;
	logic        vblank_q;
	logic        frame_start;
	logic        pix_valid;
	int          pix_x;
	int          pix_y;
	logic [11:0] pix_rgb;

	tilemap_video u_tilemap_video (
		.clk     (clk),
		.arst_n  (arst_n),
		.cpu_wr  (cpu_wr),
		.cpu_req (cpu_req),
		.cpu_ack (cpu_ack),
		.video   (video),
		.vid_ce  (vid_ce)
	);

	bind tilemap_video tilemap_video_chk u_chk (
		.clk     (clk),
		.arst_n  (arst_n),
		.cpu_req (cpu_req),
		.cpu_ack (cpu_ack),
		.video   (video)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#clk_half clk = ~clk;
		end
	end

	//////////////////////////////////////////////////
	// Raster tracking and frame geometry
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		pix_valid   = 1'b0;
		frame_start = 1'b0;
		if (arst_n && vid_ce) begin
			// Rising vblank_n marks the first pixel of a frame
			if (video.vblank_n && !vblank_q) begin
				// One hsync per line and one vsync in the frame just ended
				if (frame_cnt != 0) begin
					check_cnt++;
					if (hs_pulses != `TM_V_TOTAL || vs_pulses != 1) begin
						err_cnt++;
						$display("Fail at %0t: %0d hsync and %0d vsync pulses, expected %0d and 1",
							$time, hs_pulses, vs_pulses, `TM_V_TOTAL);
					end
				end
				frame_cnt++;
				hs_pulses   = 0;
				vs_pulses   = 0;
				frame_start = 1'b1;
				x_cnt       = 0;
				y_cnt       = 0;
			end
			if (!video.vblank_n) begin
				if (vblank_q) begin
					check_cnt++;
					if (y_cnt != `TM_V_ACTIVE) begin
						err_cnt++;
						$display("Fail at %0t: frame had %0d active lines, expected %0d",
							$time, y_cnt, `TM_V_ACTIVE);
					end
				end
				x_cnt = 0;
				y_cnt = 0;
			end else if (!video.hblank_n) begin
				// First blank sample after a line closes it
				if (x_cnt != 0) begin
					check_cnt++;
					if (x_cnt != `TM_H_ACTIVE) begin
						err_cnt++;
						$display("Fail at %0t: line %0d had %0d active pixels, expected %0d",
							$time, y_cnt, x_cnt, `TM_H_ACTIVE);
					end
					y_cnt++;
					x_cnt = 0;
				end
			end else begin
				pix_valid = 1'b1;
				pix_x     = x_cnt;
				pix_y     = y_cnt;
				pix_rgb   = {video.red, video.green, video.blue};
				x_cnt++;
			end
			// Sync pulse widths
			if (!video.hsync_n) begin
				hs_cnt++;
			end else if (hs_cnt != 0) begin
				check_cnt++;
				if (hs_cnt != hsync_len) begin
					err_cnt++;
					$display("Fail at %0t: hsync lasted %0d pixels, expected %0d",
						$time, hs_cnt, hsync_len);
				end
				hs_cnt = 0;
				hs_pulses++;
			end
			if (!video.vsync_n) begin
				vs_cnt++;
			end else if (vs_cnt != 0) begin
				check_cnt++;
				if (vs_cnt != vsync_len) begin
					err_cnt++;
					$display("Fail at %0t: vsync lasted %0d pixels, expected %0d",
						$time, vs_cnt, vsync_len);
				end
				vs_cnt = 0;
				vs_pulses++;
			end
			vblank_q = video.vblank_n;
		end
	end

	//////////////////////////////////////////////////
	// Command tasks
	//////////////////////////////////////////////////

	// Full four-phase write on the CPU port
	task automatic cpu_write(input logic [7:0] addr, input logic [11:0] data);
		int waited;
		@(negedge clk);
		cpu_wr.addr = addr;
		cpu_wr.data = data;
		cpu_req     = 1'b1;
		waited      = 0;
		while (!cpu_ack && waited < ack_limit) begin
			@(negedge clk);
			waited++;
		end
		if (!cpu_ack) begin
			err_cnt++;
			timed_out = 1'b1;
			$display("Timeout: cpu_ack never rose for the write to address %h", addr);
		end else begin
			cpu_req = 1'b0;
			waited  = 0;
			while (cpu_ack && waited < ack_limit) begin
				@(negedge clk);
				waited++;
			end
			if (cpu_ack) begin
				err_cnt++;
				timed_out = 1'b1;
				$display("Timeout: cpu_ack stayed high after the write to address %h", addr);
			end
		end
	endtask

	// Tracker flags are read on the rising edge half a clock after they settle
	task automatic wait_frame();
		int waited;
		waited = 0;
		@(posedge clk);
		while (!frame_start && waited < frame_limit) begin
			@(posedge clk);
			waited++;
		end
		if (!frame_start) begin
			err_cnt++;
			timed_out = 1'b1;
			$display("Timeout: no new frame started");
		end
	endtask

	task automatic check_pixel(input int x, input int y, input logic [11:0] rgb);
		int waited;
		waited = 0;
		@(posedge clk);
		while (!(pix_valid && pix_x == x && pix_y == y) && waited < frame_limit) begin
			@(posedge clk);
			waited++;
		end
		if (!(pix_valid && pix_x == x && pix_y == y)) begin
			err_cnt++;
			timed_out = 1'b1;
			$display("Timeout: pixel (%0d,%0d) never appeared on the video output", x, y);
		end else begin
			check_cnt++;
			pix_checks++;
			if (pix_rgb !== rgb) begin
				err_cnt++;
				$display("Fail at %0t: pixel (%0d,%0d) is %h, expected %h",
					$time, x, y, pix_rgb, rgb);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		int            fd;
		int            code;
		int            px;
		int            py;
		int            total;
		logic [63:0]   cmd;
		logic [1279:0] line;
		logic [7:0]    addr;
		logic [11:0]   data;
		logic [11:0]   rgb;

		arst_n      = 1'b0;
		cpu_req     = 1'b0;
		cpu_wr      = '0;
		err_cnt     = 0;
		check_cnt   = 0;
		pix_checks  = 0;
		timed_out   = 1'b0;
		x_cnt       = 0;
		y_cnt       = 0;
		hs_cnt      = 0;
		vs_cnt      = 0;
		hs_pulses   = 0;
		vs_pulses   = 0;
		frame_cnt   = 0;
		vblank_q    = 1'b0;
		frame_start = 1'b0;
		pix_valid   = 1'b0;
		pix_x       = 0;
		pix_y       = 0;
		pix_rgb     = '0;

		// Reset held for 4 clocks with outputs checked while it is low
		repeat (4) @(negedge clk);
		check_cnt++;
		if (!video.hsync_n || !video.vsync_n || video.hblank_n || video.vblank_n
			|| cpu_ack || vid_ce) begin
			err_cnt++;
			$display("Fail at %0t: reset values wrong, flags %b cpu_ack %b vid_ce %b",
				$time, {video.hsync_n, video.vsync_n, video.hblank_n, video.vblank_n},
				cpu_ack, vid_ce);
		end
		arst_n = 1'b1;

		fd = $fopen("bench/tilemap_video_tests.txt", "r");
		if (fd == 0) begin
			err_cnt++;
			$display("Could not open bench/tilemap_video_tests.txt");
		end else begin
			while (!timed_out && $fscanf(fd, "%s", cmd) == 1) begin
				if (cmd == "#") begin
					code = $fgets(line, fd);
				end else if (cmd == "W") begin
					code = $fscanf(fd, "%h %h", addr, data);
					if (code != 2) begin
						err_cnt++;
						$display("Malformed write command in the test file");
					end else begin
						cpu_write(addr, data);
					end
				end else if (cmd == "F") begin
					wait_frame();
				end else if (cmd == "C") begin
					code = $fscanf(fd, "%d %d %h", px, py, rgb);
					if (code != 3) begin
						err_cnt++;
						$display("Malformed pixel check in the test file");
					end else begin
						check_pixel(px, py, rgb);
					end
				end else begin
					err_cnt++;
					$display("Unknown command %0s in the test file", cmd);
				end
			end
			$fclose(fd);
		end

		if (pix_checks == 0) begin
			err_cnt++;
			$display("No pixel checks were run");
		end

		total = err_cnt + u_tilemap_video.u_chk.assert_errs;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			check_cnt, err_cnt, u_tilemap_video.u_chk.assert_errs);
		if (total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== bench/tilemap_video_chk.sv ====
`timescale 1ns/1ns

module tilemap_video_chk (
	input logic                    clk,
	input logic                    arst_n,
	input logic                    cpu_req,
	input logic                    cpu_ack,
	input tilemap_pkg::video_out_t video
);

	int assert_errs = 0;

	//////////////////////////////////////////////////
	// CPU four-phase handshake
	//////////////////////////////////////////////////

	// Req may only drop once ack is up
	a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(cpu_req) |-> cpu_ack)
	else begin
		assert_errs = assert_errs + 1;
		$error("cpu_req fell before cpu_ack rose");
	end

	// Ack follows req down
	a_ack_release: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(cpu_ack) |-> !$past(cpu_req))
	else begin
		assert_errs = assert_errs + 1;
		$error("cpu_ack fell while cpu_req was still high");
	end

	//////////////////////////////////////////////////
	// Syncs inside blanking
	//////////////////////////////////////////////////

	a_hsync_blank: assert property (@(posedge clk) disable iff (!arst_n)
		!video.hsync_n |-> !video.hblank_n)
	else begin
		assert_errs = assert_errs + 1;
		$error("hsync_n low outside horizontal blanking");
	end

	a_vsync_blank: assert property (@(posedge clk) disable iff (!arst_n)
		!video.vsync_n |-> !video.vblank_n)
	else begin
		assert_errs = assert_errs + 1;
		$error("vsync_n low outside vertical blanking");
	end

endmodule

// ==== hw/tilemap_video.sv ====
`timescale 1ns/1ns
`include "tilemap_config.svh"

module tilemap_video (
	input  logic                    clk,
	input  logic                    arst_n,
	input  tilemap_pkg::cpu_wr_t    cpu_wr,
	input  logic                    cpu_req,
	output logic                    cpu_ack,
	output tilemap_pkg::video_out_t video,
	output logic                    vid_ce
);
	import tilemap_pkg::*;

	logic         pix_ce;
	beam_t        beam;
	scroll_wr_t   scroll_wr;
	pal_wr_t      pal_wr;
	vram_rd_req_t bg_rd_req;
	vram_rd_req_t fg_rd_req;
	logic         bg_req;
	logic         bg_ack;
	logic         fg_req;
	logic         fg_ack;
	tile_entry_t  rd_data;
	layer_pix_t   bg_pix;
	layer_pix_t   fg_pix;

	video_timing u_video_timing (
		.clk    (clk),
		.arst_n (arst_n),
		.pix_ce (pix_ce),
		.beam   (beam)
	);

	// Background layer, scroll strobe 0
	layer_fetch #(
		.layer_base (int'(`TM_ADDR_BG_BASE)),
		.layer_sel  (0)
	) u_bg_fetch (
		.clk       (clk),
		.arst_n    (arst_n),
		.pix_ce    (pix_ce),
		.beam      (beam),
		.scroll_wr (scroll_wr),
		.rd_req    (bg_rd_req),
		.req       (bg_req),
		.ack       (bg_ack),
		.rd_data   (rd_data),
		.pix       (bg_pix)
	);

	// Foreground layer, scroll strobe 1
	layer_fetch #(
		.layer_base (int'(`TM_ADDR_FG_BASE)),
		.layer_sel  (1)
	) u_fg_fetch (
		.clk       (clk),
		.arst_n    (arst_n),
		.pix_ce    (pix_ce),
		.beam      (beam),
		.scroll_wr (scroll_wr),
		.rd_req    (fg_rd_req),
		.req       (fg_req),
		.ack       (fg_ack),
		.rd_data   (rd_data),
		.pix       (fg_pix)
	);

	vram_bus u_vram_bus (
		.clk       (clk),
		.arst_n    (arst_n),
		.bg_rd_req (bg_rd_req),
		.bg_req    (bg_req),
		.bg_ack    (bg_ack),
		.fg_rd_req (fg_rd_req),
		.fg_req    (fg_req),
		.fg_ack    (fg_ack),
		.rd_data   (rd_data),
		.cpu_wr    (cpu_wr),
		.cpu_req   (cpu_req),
		.cpu_ack   (cpu_ack),
		.pal_wr    (pal_wr),
		.scroll_wr (scroll_wr)
	);

	layer_mixer u_layer_mixer (
		.clk    (clk),
		.arst_n (arst_n),
		.pix_ce (pix_ce),
		.beam   (beam),
		.bg_pix (bg_pix),
		.fg_pix (fg_pix),
		.pal_wr (pal_wr),
		.video  (video),
		.vid_ce (vid_ce)
	);

endmodule

// ==== hw/layer_mixer.sv ====
`timescale 1ns/1ns

module layer_mixer (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    pix_ce,
	input  tilemap_pkg::beam_t      beam,
	input  tilemap_pkg::layer_pix_t bg_pix,
	input  tilemap_pkg::layer_pix_t fg_pix,
	input  tilemap_pkg::pal_wr_t    pal_wr,
	output tilemap_pkg::video_out_t video,
	output logic                    vid_ce
);
	import tilemap_pkg::*;

	localparam int pal_size = 32;

	palette_entry_t pal_ram [pal_size];
	palette_entry_t pix_color;
	logic [4:0]     pal_idx;
	logic           blank;

	// Palette RAM, cleared to black
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < pal_size; i++) begin
				pal_ram[i] <= '0;
			end
		end else if (pal_wr.we) begin
			pal_ram[pal_wr.idx] <= pal_wr.color;
		end
	end

	// FG pens in upper half of palette
	assign pal_idx   = fg_pix.opaque ? {1'b1, fg_pix.pen} : {1'b0, bg_pix.pen};
	assign pix_color = pal_ram[pal_idx];
	assign blank     = beam.hblank || beam.vblank;

	//////////////////////////////////////////////////
	// Output register, colour and flags together
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			video.red      <= '0;
			video.green    <= '0;
			video.blue     <= '0;
			video.hsync_n  <= 1'b1;
			video.vsync_n  <= 1'b1;
			video.hblank_n <= 1'b0;
			video.vblank_n <= 1'b0;
			vid_ce         <= 1'b0;
		end else begin
			vid_ce <= pix_ce;
			if (pix_ce) begin
				// Black outside active area
				video.red      <= blank ? 4'h0 : pix_color.red;
				video.green    <= blank ? 4'h0 : pix_color.green;
				video.blue     <= blank ? 4'h0 : pix_color.blue;
				video.hsync_n  <= ~beam.hsync;
				video.vsync_n  <= ~beam.vsync;
				video.hblank_n <= ~beam.hblank;
				video.vblank_n <= ~beam.vblank;
			end
		end
	end

endmodule

// ==== hw/vram_bus.sv ====
`timescale 1ns/1ns
`include "tilemap_config.svh"

module vram_bus (
	input  logic                      clk,
	input  logic                      arst_n,
	input  tilemap_pkg::vram_rd_req_t bg_rd_req,
	input  logic                      bg_req,
	output logic                      bg_ack,
	input  tilemap_pkg::vram_rd_req_t fg_rd_req,
	input  logic                      fg_req,
	output logic                      fg_ack,
	output tilemap_pkg::tile_entry_t  rd_data,
	input  tilemap_pkg::cpu_wr_t      cpu_wr,
	input  logic                      cpu_req,
	output logic                      cpu_ack,
	output tilemap_pkg::pal_wr_t      pal_wr,
	output tilemap_pkg::scroll_wr_t   scroll_wr
);
	import tilemap_pkg::*;

	localparam int peer_bg  = 0;
	localparam int peer_fg  = 1;
	localparam int peer_cpu = 2;

	tile_entry_t    tile_ram [64];
	tile_entry_t    rd_data_q;
	logic [2:0]     req_vec;
	logic [2:0]     ack_q;
	logic [2:0]     grant;
	logic [1:0]     last_q;
	logic [5:0]     rd_addr;
	logic           cpu_is_tile;
	logic           cpu_is_pal;
	logic           cpu_is_bg_scroll;
	logic           cpu_is_fg_scroll;
	logic           pal_we_q;
	logic [1:0]     scroll_we_q;
	logic [4:0]     pal_idx_q;
	palette_entry_t pal_color_q;
	logic [5:0]     scroll_val_q;

	assign req_vec = {cpu_req, fg_req, bg_req};

	//////////////////////////////////////////////////
	// Round-robin grant
	//////////////////////////////////////////////////

	// Search starts after the last granted peer; bus idle only with all acks low
	always_comb begin
		int idx;
		grant = '0;
		for (int i = 1; i <= 3; i++) begin
			idx = int'(last_q) + i;
			if (idx >= 3) begin
				idx = idx - 3;
			end
			if (req_vec[idx] && (grant == 3'b000) && (ack_q == 3'b000)) begin
				grant[idx] = 1'b1;
			end
		end
	end

	assign rd_addr = grant[peer_fg] ? fg_rd_req.addr : bg_rd_req.addr;

	// CPU address decode
	assign cpu_is_tile      = (cpu_wr.addr < `TM_ADDR_PAL_BASE);
	assign cpu_is_pal       = (cpu_wr.addr >= `TM_ADDR_PAL_BASE) && (cpu_wr.addr < `TM_ADDR_SCROLL);
	assign cpu_is_bg_scroll = (cpu_wr.addr == `TM_ADDR_SCROLL);
	assign cpu_is_fg_scroll = (cpu_wr.addr == `TM_ADDR_SCROLL + 8'd1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_q       <= '0;
			last_q      <= 2'd2;
			pal_we_q    <= 1'b0;
			scroll_we_q <= '0;
		end else begin
			// Strobes last a single clock
			pal_we_q    <= 1'b0;
			scroll_we_q <= '0;
			// Ack follows req down
			ack_q <= ack_q & req_vec;
			if (grant != 3'b000) begin
				ack_q <= grant;
				case (grant)
					3'b010:  last_q <= 2'd1;
					3'b100:  last_q <= 2'd2;
					default: last_q <= 2'd0;
				endcase
				if (grant[peer_cpu]) begin
					pal_we_q    <= cpu_is_pal;
					scroll_we_q <= {cpu_is_fg_scroll, cpu_is_bg_scroll};
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Tile RAM and write payloads
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (grant[peer_bg] || grant[peer_fg]) begin
			rd_data_q <= tile_ram[rd_addr];
		end
		if (grant[peer_cpu]) begin
			if (cpu_is_tile) begin
				tile_ram[cpu_wr.addr[5:0]] <= cpu_wr.data.tile;
			end
			pal_idx_q    <= cpu_wr.addr[4:0];
			pal_color_q  <= cpu_wr.data.pal;
			// Scroll in the low bits of the word
			scroll_val_q <= cpu_wr.data[5:0];
		end
	end

	assign bg_ack  = ack_q[peer_bg];
	assign fg_ack  = ack_q[peer_fg];
	assign cpu_ack = ack_q[peer_cpu];
	assign rd_data = rd_data_q;

	assign pal_wr.idx      = pal_idx_q;
	assign pal_wr.color    = pal_color_q;
	assign pal_wr.we       = pal_we_q;
	assign scroll_wr.value = scroll_val_q;
	assign scroll_wr.we    = scroll_we_q;

endmodule

// ==== hw/layer_fetch.sv ====
`timescale 1ns/1ns
`include "tilemap_config.svh"

module layer_fetch #(
	parameter int layer_base = 0,
	parameter int layer_sel  = 0
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      pix_ce,
	input  tilemap_pkg::beam_t        beam,
	input  tilemap_pkg::scroll_wr_t   scroll_wr,
	output tilemap_pkg::vram_rd_req_t rd_req,
	output logic                      req,
	input  logic                      ack,
	input  tilemap_pkg::tile_entry_t  rd_data,
	output tilemap_pkg::layer_pix_t   pix
);
	import tilemap_pkg::*;

	localparam int col_bits = $clog2(`TM_TILE_COLS);
	localparam int row_bits = $clog2(`TM_TILE_ROWS);

	// Requester states
	localparam logic [1:0] st_idle    = 2'd0;
	localparam logic [1:0] st_req     = 2'd1;
	localparam logic [1:0] st_release = 2'd2;

	logic [5:0]          scroll_q;
	logic [5:0]          scroll_x;
	logic [5:0]          next_line;
	logic [1:0]          state_q;
	logic [1:0]          fetch_cnt;
	logic                fetch_cur;
	logic [col_bits-1:0] fetch_col;
	logic [row_bits-1:0] fetch_row;
	logic                tile_edge;
	logic                line_load;
	tile_entry_t         cur_tile;
	tile_entry_t         nxt_tile;

	// Layer scroll, written by its own strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scroll_q <= '0;
		end else if (scroll_wr.we[layer_sel]) begin
			scroll_q <= scroll_wr.value;
		end
	end

	// Scrolled x, wraps at 64
	assign scroll_x  = beam.hpos[5:0] + scroll_q;
	assign next_line = (beam.vpos == 6'(`TM_V_TOTAL - 1)) ? 6'd0 : beam.vpos + 6'd1;

	// Last pixel of a tile, beam moves into the next one on this pix_ce
	assign tile_edge = pix_ce && !beam.vblank && (scroll_x[2:0] == 3'd7)
		&& (beam.hpos < 7'(`TM_H_ACTIVE - 1));
	// Two-tile preload for the coming line, once any tail fetch has drained
	assign line_load = pix_ce && (beam.hpos == 7'(`TM_HSYNC_START));

	//////////////////////////////////////////////////
	// Fetch control and tile registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q   <= st_idle;
			fetch_cnt <= '0;
			fetch_cur <= 1'b0;
			fetch_col <= '0;
			fetch_row <= '0;
			cur_tile  <= '0;
			nxt_tile  <= '0;
		end else begin
			case (state_q)
				st_idle: begin
					if (fetch_cnt != 2'd0) begin
						state_q <= st_req;
					end
				end
				st_req: begin
					// Data valid while ack high
					if (ack) begin
						if (fetch_cur) begin
							cur_tile <= rd_data;
						end else begin
							nxt_tile <= rd_data;
						end
						fetch_cur <= 1'b0;
						fetch_col <= fetch_col + 1'b1;
						fetch_cnt <= fetch_cnt - 2'd1;
						state_q   <= st_release;
					end
				end
				st_release: begin
					if (!ack) begin
						state_q <= st_idle;
					end
				end
				default: state_q <= st_idle;
			endcase

			if (line_load) begin
				fetch_cnt <= 2'd2;
				fetch_cur <= 1'b1;
				fetch_col <= scroll_q[3 +: col_bits];
				fetch_row <= next_line[3 +: row_bits];
			end

			// Shift in the prefetched tile, ask for the one after
			if (tile_edge) begin
				cur_tile  <= nxt_tile;
				fetch_cnt <= 2'd1;
				fetch_cur <= 1'b0;
				fetch_col <= scroll_x[3 +: col_bits] + col_bits'(2);
				fetch_row <= beam.vpos[3 +: row_bits];
			end
		end
	end

	assign req         = (state_q == st_req);
	assign rd_req.addr = 6'(layer_base) + 6'({fetch_row, fetch_col});

	// Solid tiles, pen is the same for every pixel of the tile
	assign pix.pen    = cur_tile.pen;
	assign pix.opaque = cur_tile.opaque;

endmodule

// ==== hw/video_timing.sv ====
`timescale 1ns/1ns
`include "tilemap_config.svh"

module video_timing (
	input  logic               clk,
	input  logic               arst_n,
	output logic               pix_ce,
	output tilemap_pkg::beam_t beam
);

	logic       ce_q;
	logic [6:0] h_cnt;
	logic [5:0] v_cnt;

	// Pixel enable on every second clock
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ce_q <= 1'b0;
		end else begin
			ce_q <= ~ce_q;
		end
	end

	assign pix_ce = ce_q;

	//////////////////////////////////////////////////
	// Raster counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pix_ce) begin
			if (h_cnt == 7'(`TM_H_TOTAL - 1)) begin
				h_cnt <= '0;
				// End of frame wraps to line 0
				if (v_cnt == 6'(`TM_V_TOTAL - 1)) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 6'd1;
				end
			end else begin
				h_cnt <= h_cnt + 7'd1;
			end
		end
	end

	// Sync and blank decode, all active high here
	always_comb begin
		beam.hpos   = h_cnt;
		beam.vpos   = v_cnt;
		beam.hblank = (h_cnt >= 7'(`TM_H_ACTIVE));
		beam.vblank = (v_cnt >= 6'(`TM_V_ACTIVE));
		beam.hsync  = (h_cnt >= 7'(`TM_HSYNC_START)) && (h_cnt <= 7'(`TM_HSYNC_END));
		beam.vsync  = (v_cnt >= 6'(`TM_VSYNC_START)) && (v_cnt <= 6'(`TM_VSYNC_END));
	end

endmodule

// ==== hw/tilemap_pkg.sv ====
package tilemap_pkg;

	//////////////////////////////////////////////////
	// Memory words
	//////////////////////////////////////////////////

	// Tile RAM word, one solid pen per tile
	typedef struct packed {
		logic [6:0] rsvd;
		logic       opaque;
		logic [3:0] pen;
	} tile_entry_t;

	// Palette colour
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} palette_entry_t;

	// CPU data word, meaning depends on target region
	typedef union packed {
		tile_entry_t    tile;
		palette_entry_t pal;
	} cpu_word_u;

	//////////////////////////////////////////////////
	// Bus payloads
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [7:0] addr;
		cpu_word_u  data;
	} cpu_wr_t;

	// Fetcher read address into tile RAM
	typedef struct packed {
		logic [5:0] addr;
	} vram_rd_req_t;

	typedef struct packed {
		logic [4:0]     idx;
		palette_entry_t color;
		logic           we;
	} pal_wr_t;

	// we[0] bg layer, we[1] fg layer
	typedef struct packed {
		logic [5:0] value;
		logic [1:0] we;
	} scroll_wr_t;

	//////////////////////////////////////////////////
	// Video path
	//////////////////////////////////////////////////

	// Beam position plus active-high sync/blank
	typedef struct packed {
		logic [6:0] hpos;
		logic [5:0] vpos;
		logic       hblank;
		logic       vblank;
		logic       hsync;
		logic       vsync;
	} beam_t;

	typedef struct packed {
		logic       opaque;
		logic [3:0] pen;
	} layer_pix_t;

	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
		logic       hsync_n;
		logic       vsync_n;
		logic       hblank_n;
		logic       vblank_n;
	} video_out_t;

endpackage

// ==== hw/tilemap_config.svh ====
`ifndef TILEMAP_CONFIG_SVH
`define TILEMAP_CONFIG_SVH

//////////////////////////////////////////////////
// Raster timing, in pixels and lines
//////////////////////////////////////////////////

`define TM_H_ACTIVE      64
`define TM_H_TOTAL       96
// Sync pulse spans pixels 72..79 inclusive
`define TM_HSYNC_START   72
`define TM_HSYNC_END     79

`define TM_V_ACTIVE      32
`define TM_V_TOTAL       40
`define TM_VSYNC_START   34
`define TM_VSYNC_END     35

// Tile grid per layer, tiles are 8x8
`define TM_TILE_COLS     8
`define TM_TILE_ROWS     4

//////////////////////////////////////////////////
// CPU address map
//////////////////////////////////////////////////

`define TM_ADDR_BG_BASE  8'h00
`define TM_ADDR_FG_BASE  8'h20
`define TM_ADDR_PAL_BASE 8'h40
// BG scroll here, FG scroll one above
`define TM_ADDR_SCROLL   8'h60

`endif
